/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

endpackage

`default_nettype wire

/* hdl/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

  import rv_isa_pkg::*;

  // --------------------------------------------------
  // wishbone classic
  // --------------------------------------------------
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // --------------------------------------------------
  // stage bundles
  // --------------------------------------------------
  typedef struct packed {
    word_t    pc;
    word_t    op1;
    word_t    op2;
    alu_op_e  alu_op;
    reg_idx_t rd;
    logic     rd_wen;
    logic     is_branch;
    br_cond_e br_cond;
    word_t    br_a;
    word_t    br_b;
    logic     is_jump;
    word_t    jump_base;  // pc for jal, rs1 for jalr
    word_t    imm;
    logic     illegal;
  } dec_op_t;

  typedef struct packed {
    logic  valid;
    word_t next_pc;
  } redirect_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    logic     wen;
    word_t    wdata;
  } retire_t;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_isa_pkg::*; import core_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      run_i,
  input  word_t     start_pc_i,
  input  redirect_t redirect_i,
  output wb_req_t   ibus_req_o,
  input  wb_rsp_t   ibus_rsp_i,
  output logic      valid_o,
  input  logic      ready_i,
  output inst_t     inst_o,
  output word_t     pc_o
);

  typedef enum logic [1:0] {IDLE, BUS, OFFER, WAIT_REDIRECT} state_e;

  state_e state;
  word_t  pc_q;

  always_comb begin
    ibus_req_o     = '0;
    ibus_req_o.cyc = (state == BUS);
    ibus_req_o.stb = (state == BUS);
    ibus_req_o.adr = pc_q;
    ibus_req_o.sel = 4'hf;  // always a full word read
  end

  assign valid_o = (state == OFFER);
  assign pc_o    = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (run_i) begin
            pc_q  <= start_pc_i;
            state <= BUS;
          end
        end
        BUS: begin
          // the bus cycle is always completed, even if run has dropped
          if (ibus_rsp_i.ack) begin
            inst_o <= ibus_rsp_i.dat;
            state  <= run_i ? OFFER : IDLE;
          end
        end
        OFFER: begin
          if (ready_i) state <= WAIT_REDIRECT;
        end
        WAIT_REDIRECT: begin
          if (redirect_i.valid) begin
            pc_q  <= redirect_i.next_pc;
            state <= run_i ? BUS : IDLE;
          end else if (!run_i) begin
            state <= IDLE;  // halted, no redirect will come
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_isa_pkg::*; import core_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  output logic     ready_o,
  input  inst_t    inst_i,
  input  word_t    pc_i,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  input  word_t    rdata1_i,
  input  word_t    rdata2_i,
  output logic     valid_o,
  input  logic     ready_i,
  output dec_op_t  op_o
);

  inst_t      inst_q;
  word_t      pc_q;
  logic [6:0] funct7;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end else if (valid_i && ready_o) begin
      inst_q  <= inst_i;
      pc_q    <= pc_i;
      valid_o <= 1'b1;
      ready_o <= 1'b0;
    end else if (valid_o && ready_i) begin
      valid_o <= 1'b0;
      ready_o <= 1'b1;
    end
  end

  // --------------------------------------------------
  // fields and immediates
  // --------------------------------------------------
  assign rs1_o  = inst_q[19:15];
  assign rs2_o  = inst_q[24:20];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    op_o           = '0;
    op_o.pc        = pc_q;
    op_o.rd        = inst_q[11:7];
    op_o.alu_op    = ALU_ADD;
    op_o.br_cond   = br_cond_e'(funct3);
    op_o.br_a      = rdata1_i;
    op_o.br_b      = rdata2_i;
    op_o.jump_base = pc_q;
    case (inst_q[6:0])
      OPC_LUI: begin
        op_o.op2    = imm_u;
        op_o.rd_wen = 1'b1;
      end
      OPC_AUIPC: begin
        op_o.op1    = pc_q;
        op_o.op2    = imm_u;
        op_o.rd_wen = 1'b1;
      end
      OPC_JAL: begin
        op_o.op1     = pc_q;  // link value is pc + 4
        op_o.op2     = 32'd4;
        op_o.rd_wen  = 1'b1;
        op_o.is_jump = 1'b1;
        op_o.imm     = imm_j;
      end
      OPC_JALR: begin
        op_o.op1       = pc_q;
        op_o.op2       = 32'd4;
        op_o.rd_wen    = 1'b1;
        op_o.is_jump   = 1'b1;
        op_o.jump_base = rdata1_i;
        op_o.imm       = imm_i;
        op_o.illegal   = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        op_o.is_branch = 1'b1;
        op_o.imm       = imm_b;
        op_o.illegal   = (funct3[2:1] == 2'b01);  // 010 and 011 are reserved
      end
      OPC_OP_IMM: begin
        op_o.op1    = rdata1_i;
        op_o.op2    = imm_i;
        op_o.imm    = imm_i;
        op_o.rd_wen = 1'b1;
        op_o.alu_op = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        if (funct3 == 3'b001 && funct7 != 7'b0000000)
          op_o.illegal = 1'b1;
        if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000)
          op_o.illegal = 1'b1;
      end
      OPC_OP: begin
        op_o.op1    = rdata1_i;
        op_o.op2    = rdata2_i;
        op_o.rd_wen = 1'b1;
        op_o.alu_op = alu_op_e'({funct7[5], funct3});
        if (funct7 == 7'b0100000)
          op_o.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);  // only sub and sra
        else if (funct7 != 7'b0000000)
          op_o.illegal = 1'b1;
      end
      default: op_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_isa_pkg::*; import core_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid_i,
  output logic      ready_o,
  input  dec_op_t   op_i,
  output logic      rf_we_o,
  output reg_idx_t  rf_waddr_o,
  output word_t     rf_wdata_o,
  output redirect_t redirect_o,
  output retire_t   retire_o,
  output logic      halt_o
);

  word_t      alu_res;
  word_t      jump_tgt;
  word_t      next_pc;
  logic       taken;
  logic       wen;
  logic       commit;
  logic [4:0] shamt;

  assign ready_o = 1'b1;  // one instruction in flight, so execute never stalls
  assign shamt   = op_i.op2[4:0];

  always_comb begin
    case (op_i.alu_op)
      ALU_ADD:  alu_res = op_i.op1 + op_i.op2;
      ALU_SUB:  alu_res = op_i.op1 - op_i.op2;
      ALU_SLL:  alu_res = op_i.op1 << shamt;
      ALU_SLT:  alu_res = {31'b0, $signed(op_i.op1) < $signed(op_i.op2)};
      ALU_SLTU: alu_res = {31'b0, op_i.op1 < op_i.op2};
      ALU_XOR:  alu_res = op_i.op1 ^ op_i.op2;
      ALU_SRL:  alu_res = op_i.op1 >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(op_i.op1) >>> shamt);
      ALU_OR:   alu_res = op_i.op1 | op_i.op2;
      ALU_AND:  alu_res = op_i.op1 & op_i.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (op_i.br_cond)
      BR_EQ:   taken = (op_i.br_a == op_i.br_b);
      BR_NE:   taken = (op_i.br_a != op_i.br_b);
      BR_LT:   taken = ($signed(op_i.br_a) < $signed(op_i.br_b));
      BR_GE:   taken = ($signed(op_i.br_a) >= $signed(op_i.br_b));
      BR_LTU:  taken = (op_i.br_a < op_i.br_b);
      BR_GEU:  taken = (op_i.br_a >= op_i.br_b);
      default: taken = 1'b0;
    endcase
  end

  // bit 0 matters only for jalr, a jal target is already even
  assign jump_tgt = (op_i.jump_base + op_i.imm) & ~32'd1;

  always_comb begin
    if (op_i.is_jump)
      next_pc = jump_tgt;
    else if (op_i.is_branch && taken)
      next_pc = op_i.pc + op_i.imm;
    else
      next_pc = op_i.pc + 32'd4;
  end

  assign wen    = op_i.rd_wen && (op_i.rd != '0);
  assign commit = valid_i && !op_i.illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      rf_we_o          <= 1'b0;
      redirect_o.valid <= 1'b0;
      retire_o.valid   <= 1'b0;
      halt_o           <= 1'b0;
    end else begin
      rf_we_o          <= commit && wen;
      redirect_o.valid <= commit;
      retire_o.valid   <= commit;
      halt_o           <= valid_i && op_i.illegal;
      if (valid_i) begin
        rf_waddr_o         <= op_i.rd;
        rf_wdata_o         <= alu_res;
        redirect_o.next_pc <= next_pc;
        retire_o.pc        <= op_i.pc;
        retire_o.rd        <= op_i.rd;
        retire_o.wen       <= wen;
        retire_o.wdata     <= alu_res;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t raddr1_i,
  input  reg_idx_t raddr2_i,
  output word_t    rdata1_o,
  output word_t    rdata2_o,
  input  logic     we_i,
  input  reg_idx_t waddr_i,
  input  word_t    wdata_i
);

  word_t regs [1:31];  // x0 has no storage

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/core_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_regs import rv_isa_pkg::*; import core_bus_pkg::*; #(
  parameter int cnt_width = 32
) (
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  input  logic    retire_i,
  input  logic    halt_i,
  output logic    run_o,
  output word_t   start_pc_o
);

  logic                 halted;
  logic [cnt_width-1:0] retired;
  logic                 access;
  logic                 wr;
  logic [1:0]           reg_sel;
  word_t                rdata;

  // a new access is taken only while ack is low, so ack is a single pulse
  assign access  = wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack;
  assign wr      = access && wb_req_i.we;
  assign reg_sel = wb_req_i.adr[3:2];

  always_comb begin
    case (reg_sel)
      2'd0:    rdata = {31'b0, run_o};
      2'd1:    rdata = start_pc_o;
      2'd2:    rdata = {31'b0, halted};
      default: rdata = word_t'(retired);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_rsp_o.ack <= 1'b0;
      run_o        <= 1'b0;
      halted       <= 1'b0;
      retired      <= '0;
      start_pc_o   <= '0;
    end else begin
      wb_rsp_o.ack <= access;
      if (retire_i) retired <= retired + 1'b1;
      if (halt_i) begin
        run_o  <= 1'b0;
        halted <= 1'b1;
      end
      // a host start wins over a halt in the same cycle
      if (wr && reg_sel == 2'd0 && wb_req_i.sel[0]) begin
        run_o <= wb_req_i.dat[0];
        if (wb_req_i.dat[0]) begin
          halted  <= 1'b0;
          retired <= '0;
        end
      end
      if (wr && reg_sel == 2'd1) begin
        for (int b = 0; b < 4; b++)
          if (wb_req_i.sel[b]) start_pc_o[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
      end
    end
    if (access) wb_rsp_o.dat <= rdata;
  end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import rv_isa_pkg::*; import core_bus_pkg::*; #(
  parameter int cnt_width = 32
) (
  input  logic    clk,
  input  logic    rst,
  output wb_req_t ibus_req_o,
  input  wb_rsp_t ibus_rsp_i,
  input  wb_req_t hbus_req_i,
  output wb_rsp_t hbus_rsp_o,
  output retire_t retire_o
);

  logic      run;
  word_t     start_pc;
  redirect_t redirect;
  logic      f_valid;
  inst_t     f_inst;
  word_t     f_pc;
  logic      d_ready;
  logic      d_valid;
  dec_op_t   d_op;
  logic      e_ready;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  word_t     rdata1;
  word_t     rdata2;
  logic      rf_we;
  reg_idx_t  rf_waddr;
  word_t     rf_wdata;
  logic      halt;

  fetch_unit u_fetch (
    .clk(clk), .rst(rst),
    .run_i(run), .start_pc_i(start_pc), .redirect_i(redirect),
    .ibus_req_o(ibus_req_o), .ibus_rsp_i(ibus_rsp_i),
    .valid_o(f_valid), .ready_i(d_ready), .inst_o(f_inst), .pc_o(f_pc)
  );

  decode_unit u_decode (
    .clk(clk), .rst(rst),
    .valid_i(f_valid), .ready_o(d_ready), .inst_i(f_inst), .pc_i(f_pc),
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .valid_o(d_valid), .ready_i(e_ready), .op_o(d_op)
  );

  exec_unit u_exec (
    .clk(clk), .rst(rst),
    .valid_i(d_valid), .ready_o(e_ready), .op_i(d_op),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .redirect_o(redirect), .retire_o(retire_o), .halt_o(halt)
  );

  reg_file u_rf (
    .clk(clk), .rst(rst),
    .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  core_ctrl_regs #(.cnt_width(cnt_width)) u_ctrl (
    .clk(clk), .rst(rst),
    .wb_req_i(hbus_req_i), .wb_rsp_o(hbus_rsp_o),
    .retire_i(retire_o.valid), .halt_i(halt),
    .run_o(run), .start_pc_o(start_pc)
  );

endmodule

`default_nettype wire

/* bench/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// lw x1, idx(x0) is a load, which the core treats as illegal and halts on
function automatic inst_t illegal_word(input int unsigned idx);
  illegal_word = {12'(idx), 5'd0, 3'b010, 5'd1, 7'b0000011};
endfunction

word_t m_regs [32];
word_t m_pc;

function automatic word_t alu(input logic [2:0] f3, input logic alt, input word_t a,
                              input word_t b);
  case (f3)
    3'd0: alu = alt ? a - b : a + b;
    3'd1: alu = a << b[4:0];
    3'd2: alu = {31'b0, $signed(a) < $signed(b)};
    3'd3: alu = {31'b0, a < b};
    3'd4: alu = a ^ b;
    3'd5: begin
      if (alt) alu = $signed(a) >>> b[4:0];
      else alu = a >> b[4:0];
    end
    3'd6: alu = a | b;
    default: alu = a & b;
  endcase
endfunction

function automatic logic taken(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'd0: taken = (a == b);
    3'd1: taken = (a != b);
    3'd4: taken = ($signed(a) < $signed(b));
    3'd5: taken = ($signed(a) >= $signed(b));
    3'd6: taken = (a < b);
    default: taken = (a >= b);
  endcase
endfunction

// steps one instruction at m_pc and advances registers and pc only for a legal word
task automatic model_step(output logic legal, output logic wen, output reg_idx_t rd,
                          output word_t wdata);
  inst_t      in;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      upper;
  word_t      nxt;
  logic [2:0] f3;
  in    = prog[m_pc[7:2]];
  rd    = in[11:7];
  f3    = in[14:12];
  a     = m_regs[in[19:15]];
  b     = m_regs[in[24:20]];
  imm_i = {{20{in[31]}}, in[31:20]};
  upper = {in[31:12], 12'h000};
  legal = 1'b1;
  wen   = 1'b1;
  wdata = m_pc + 32'd4;  // link value unless overridden
  nxt   = m_pc + 32'd4;
  case (in[6:0])
    OPC_LUI:    wdata = upper;
    OPC_AUIPC:  wdata = m_pc + upper;
    OPC_JAL:    nxt = m_pc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
    OPC_JALR:   nxt = (a + imm_i) & ~32'd1;
    OPC_BRANCH: begin
      wen = 1'b0;
      if (taken(f3, a, b)) nxt = m_pc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
    end
    OPC_OP_IMM: wdata = alu(f3, (f3 == 3'd5) && in[30], a, imm_i);
    OPC_OP:     wdata = alu(f3, in[30], a, b);
    default:    legal = 1'b0;
  endcase
  if (rd == 5'd0) wen = 1'b0;
  if (legal) begin
    if (wen) m_regs[rd] = wdata;
    m_pc = nxt;
  end
endtask

// control flow only goes forward, so every program ends on word 63
function automatic inst_t gen_inst(input int unsigned idx);
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [12:0] ob;
  logic [20:0] oj;
  int unsigned tgt;
  rd  = 5'($urandom);
  rs1 = 5'($urandom);
  rs2 = 5'($urandom);
  f3  = 3'($urandom);
  imm = 12'($urandom);
  tgt = idx + 1 + $urandom % (63 - idx);
  ob  = 13'((tgt - idx) * 4);
  oj  = 21'((tgt - idx) * 4);
  case ($urandom % 16)
    0: gen_inst = {20'($urandom), rd, OPC_LUI};
    1: gen_inst = {20'($urandom), rd, OPC_AUIPC};
    2: gen_inst = {oj[20], oj[10:1], oj[11], oj[19:12], rd, OPC_JAL};
    3: gen_inst = {12'(tgt * 4 + $urandom % 2), 5'd0, 3'd0, rd, OPC_JALR};
    4, 5: begin
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // skip the reserved conditions
      gen_inst = {ob[12], ob[10:5], rs2, rs1, f3, ob[4:1], ob[11], OPC_BRANCH};
    end
    6, 7, 8, 9, 10: begin
      if (f3 == 3'd1) imm[11:5] = 7'd0;
      if (f3 == 3'd5) imm[11:5] = {1'b0, 1'($urandom), 5'd0};
      gen_inst = {imm, rs1, f3, rd, OPC_OP_IMM};
    end
    default: begin
      gen_inst = {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom) : 1'b0, 5'd0,
                  rs2, rs1, f3, rd, OPC_OP};
    end
  endcase
endfunction

task automatic gen_program(input int unsigned start);
  for (int unsigned i = 0; i < 64; i++) begin
    if (i < start || i == 63) prog[i] = illegal_word(i);
    else prog[i] = gen_inst(i);
  end
  m_pc = word_t'(start * 4);
endtask

`endif

/* bench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import rv_isa_pkg::*; import core_bus_pkg::*;;

  logic    clk;
  logic    rst;
  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp;
  wb_req_t hbus_req;
  wb_rsp_t hbus_rsp;
  retire_t retire;

  inst_t       prog [64];
  int unsigned mem_wait;
  logic        mem_busy;
  int unsigned retire_cnt;
  int unsigned run_idx;
  int unsigned start_word;
  int unsigned prev_start;
  int unsigned polls;
  word_t       rdata;
  logic        exp_legal;
  logic        exp_wen;
  reg_idx_t    exp_rd;
  word_t       exp_wdata;

  `include "rv_ref_model.svh"

  core_top #(.cnt_width(32)) uut (
    .clk(clk), .rst(rst),
    .ibus_req_o(ibus_req), .ibus_rsp_i(ibus_rsp),
    .hbus_req_i(hbus_req), .hbus_rsp_o(hbus_rsp),
    .retire_o(retire)
  );

  always #50 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act)
      stop_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
  endtask

  // --------------------------------------------------
  // instruction memory, wishbone classic slave
  // --------------------------------------------------
  always @(posedge clk) begin
    #1;
    if (rst || ibus_rsp.ack) begin
      ibus_rsp.ack = 1'b0;  // ack lasts one cycle
    end else if (ibus_req.cyc && ibus_req.stb) begin
      if (ibus_req.adr > 32'd252) stop_run("instruction fetch outside the program memory");
      if (ibus_req.we || ibus_req.sel != 4'hf)
        stop_run("instruction fetch is not a full word read");
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = $urandom % 4;
      end
      if (mem_wait == 0) begin
        ibus_rsp.ack = 1'b1;
        ibus_rsp.dat = prog[ibus_req.adr[7:2]];
        mem_busy     = 1'b0;
      end else begin
        mem_wait--;
      end
    end
  end

  task automatic host_access(input logic we, input word_t adr, input word_t wdat,
                             output word_t rdat);
    int n;
    hbus_req     = '0;
    hbus_req.cyc = 1'b1;
    hbus_req.stb = 1'b1;
    hbus_req.we  = we;
    hbus_req.adr = adr;
    hbus_req.dat = wdat;
    hbus_req.sel = 4'hf;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > 20) stop_run("host bus access got no ack");
    end while (!hbus_rsp.ack);
    rdat     = hbus_rsp.dat;
    hbus_req = '0;
  endtask

  // every retire is stepped through the model and compared
  always @(posedge clk) begin
    #1;
    if (!rst && retire.valid) begin
      check_value($sformatf("run %0d retire pc", run_idx), m_pc, retire.pc);
      model_step(exp_legal, exp_wen, exp_rd, exp_wdata);
      if (!exp_legal) stop_run("an illegal instruction was retired");
      check_value($sformatf("run %0d retire wen", run_idx), 32'(exp_wen), 32'(retire.wen));
      if (exp_wen) begin
        check_value($sformatf("run %0d retire rd", run_idx), 32'(exp_rd), 32'(retire.rd));
        check_value($sformatf("run %0d retire wdata", run_idx), exp_wdata, retire.wdata);
      end
      retire_cnt++;
    end
  end

  initial begin
    void'($urandom(83));
    clk        = 1'b0;
    rst        = 1'b1;
    ibus_rsp   = '0;
    hbus_req   = '0;
    mem_busy   = 1'b0;
    mem_wait   = 0;
    retire_cnt = 0;
    run_idx    = 0;
    prev_start = 0;
    for (int r = 0; r < 32; r++) m_regs[r] = '0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;

    for (run_idx = 0; run_idx < 8; run_idx++) begin
      start_word = 0;
      if (run_idx != 0) begin
        do start_word = $urandom % 48; while (start_word == prev_start);
      end
      prev_start = start_word;
      gen_program(start_word);
      retire_cnt = 0;
      host_access(1'b1, 32'h4, word_t'(start_word * 4), rdata);
      host_access(1'b1, 32'h0, 32'h1, rdata);

      // --------------------------------------------------
      // wait for the halt on the closing illegal word
      // --------------------------------------------------
      polls = 0;
      rdata = '0;
      while (!rdata[0]) begin
        if (polls == 1000) stop_run("core did not halt within the poll limit");
        host_access(1'b0, 32'h8, '0, rdata);
        polls++;
      end
      check_value($sformatf("run %0d halt pc", run_idx), 32'd252, m_pc);
      host_access(1'b0, 32'h0, '0, rdata);
      check_value($sformatf("run %0d ctrl run bit", run_idx), 32'h0, rdata);
      host_access(1'b0, 32'hc, '0, rdata);
      check_value($sformatf("run %0d retired count", run_idx), retire_cnt, rdata);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
hdl/rv_isa_pkg.sv
hdl/core_bus_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/core_ctrl_regs.sv
hdl/core_top.sv
bench/core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module core_tb \
		-f files.f -Mdir obj_dir
	./obj_dir/Vcore_tb | tee sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log
